// ==== vlog.f ====
source/rv_pkg.sv
source/flash_boot.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
source/ram_io.sv
source/soc_top.sv
sim/spi_flash_model.sv
sim/tb_soc.sv

// ==== Makefile ====
# Verilator build and run for the rv32i system testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
RTL_TOP   ?= soc_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_soc.sv ====
/*
 * rv32i system testbench
 * assembles a program into the flash model, boots the DUT and
 * checks every io_valid report against a reference model
 */
`timescale 1ns/1ps

module tb_soc;

  localparam logic [6:0] OPC_LUI = 7'b0110111, OPC_AUIPC = 7'b0010111, OPC_JALR = 7'b1100111;
  localparam logic [6:0] OPC_OP = 7'b0110011, OPC_OP_IMM = 7'b0010011, OPC_LOAD = 7'b0000011;
  localparam int A_ADD = 0, A_SUB = 1, A_SLL = 2, A_SLT = 3, A_SLTU = 4;
  localparam int A_XOR = 5, A_SRL = 6, A_SRA = 7, A_OR = 8, A_AND = 9;
  localparam int G_RESET = 0, G_BOOT = 1, G_ALU = 2, G_MEM = 3, G_CTRL = 4, G_ILL = 5;
  localparam logic [11:0] IO_OFF = 12'hF00;  // -256 from x0 is the output register
  localparam logic [31:0] ILLEGAL = 32'hFFFF_FFFF;

  logic clk, rst_n, flash_miso, flash_clk, flash_mosi, flash_cs, led, io_valid;
  logic [31:0] io_data;

  logic [31:0] exp_q[$];
  int          grp_q[$];
  string       name_q[$];
  int          grp_left[6];
  int          grp_err[6];
  string       grp_name[6];
  int          checks, errors, io_count, wpos, cmd_bits;
  logic [31:0] cmd_word, a_val, b_val, got_exp;
  int          got_grp;
  string       got_name;

  soc_top u_soc_top (
    .clk, .rst_n, .flash_clk, .flash_miso, .flash_mosi, .flash_cs, .led, .io_data, .io_valid
  );

  spi_flash_model u_flash (.clk, .flash_clk, .flash_cs, .flash_mosi, .flash_miso);

  always #2 clk = ~clk;

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // expected ALU result from the RV32I definitions
  function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a, b);
    case (op)
      A_ADD:   return a + b;
      A_SUB:   return a - b;
      A_SLL:   return a << b[4:0];
      A_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      A_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      A_XOR:   return a ^ b;
      A_SRL:   return a >> b[4:0];
      A_SRA:   return 32'($signed(a) >>> b[4:0]);
      A_OR:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input logic [31:0] word, input int off, input int size,
                                           input bit sgn);
    logic [31:0] sh;
    sh = word >> (8 * off);
    case (size)
      1:       return sgn ? {{24{sh[7]}}, sh[7:0]} : {24'd0, sh[7:0]};
      2:       return sgn ? {{16{sh[15]}}, sh[15:0]} : {16'd0, sh[15:0]};
      default: return sh;
    endcase
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};  // base is always x0
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put_word(input logic [31:0] w);
    for (int i = 0; i < 4; i++) u_flash.mem[(4 * wpos + i) % 256] = w[8*i +: 8];
    wpos++;
  endtask

  task automatic push_expect(input logic [31:0] v, input int g, input string n);
    exp_q.push_back(v);
    grp_q.push_back(g);
    name_q.push_back(n);
    grp_left[g]++;
  endtask

  task automatic report_io(input logic [4:0] rs);
    put_word(s_type(IO_OFF, rs, 3'b010));
  endtask

  task automatic alu_r(input int op, input logic [2:0] f3, input logic [6:0] f7, input string n);
    put_word({f7, 5'd2, 5'd1, f3, 5'd3, OPC_OP});
    report_io(5'd3);
    push_expect(alu_ref(op, a_val, b_val), G_ALU, n);
  endtask

  task automatic alu_i(input int op, input logic [2:0] f3, input logic [11:0] imm,
                       input string n);
    put_word(i_type(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
    report_io(5'd3);
    push_expect(alu_ref(op, a_val, sext12(imm)), G_ALU, n);
  endtask

  task automatic load_check(input logic [2:0] f3, input logic [11:0] addr, input logic [31:0] m,
                            input int size, input bit sgn, input string n);
    put_word(i_type(addr, 5'd0, f3, 5'd3, OPC_LOAD));
    report_io(5'd3);
    push_expect(load_ref(m, int'(addr[1:0]), size, sgn), G_MEM, n);
  endtask

  task automatic build_program();
    logic [31:0] r, m;
    logic [31:0] p;
    wpos = 0;
    // jal over an illegal slot, then a branch that must not be taken
    p = 32'(4 * wpos);
    put_word(j_type(21'd8, 5'd5));
    put_word(32'h0);
    put_word(b_type(13'd8, 5'd0, 5'd0, 3'b001));
    report_io(5'd5);
    push_expect(p + 32'd4, G_CTRL, "jal_link");
    put_word(b_type(13'd8, 5'd0, 5'd0, 3'b000));  // taken beq
    put_word(32'h0);
    p = 32'(4 * wpos);
    put_word({20'd0, 5'd7, OPC_AUIPC});
    put_word(i_type(12'd12, 5'd7, 3'b000, 5'd6, OPC_JALR));
    put_word(32'h0);
    report_io(5'd6);
    push_expect(p + 32'd8, G_CTRL, "jalr_link");
    // lui loads operand a and addi loads operand b
    r = $urandom();
    a_val = {r[31:12], 12'h000};
    put_word({r[31:12], 5'd1, OPC_LUI});
    r = $urandom();
    b_val = sext12(r[11:0]);
    put_word(i_type(r[11:0], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    alu_r(A_ADD, 3'b000, 7'h00, "add");
    alu_r(A_SUB, 3'b000, 7'h20, "sub");
    alu_r(A_SLL, 3'b001, 7'h00, "sll");
    alu_r(A_SLT, 3'b010, 7'h00, "slt");
    alu_r(A_SLTU, 3'b011, 7'h00, "sltu");
    alu_r(A_XOR, 3'b100, 7'h00, "xor");
    alu_r(A_SRL, 3'b101, 7'h00, "srl");
    alu_r(A_SRA, 3'b101, 7'h20, "sra");
    alu_r(A_OR, 3'b110, 7'h00, "or");
    alu_r(A_AND, 3'b111, 7'h00, "and");
    alu_i(A_ADD, 3'b000, 12'($urandom()), "addi");
    alu_i(A_SLT, 3'b010, 12'($urandom()), "slti");
    alu_i(A_SLTU, 3'b011, 12'($urandom()), "sltiu");
    alu_i(A_XOR, 3'b100, 12'($urandom()), "xori");
    alu_i(A_OR, 3'b110, 12'($urandom()), "ori");
    alu_i(A_AND, 3'b111, 12'($urandom()), "andi");
    alu_i(A_SLL, 3'b001, {7'h00, 5'($urandom())}, "slli");
    alu_i(A_SRL, 3'b101, {7'h00, 5'($urandom())}, "srli");
    alu_i(A_SRA, 3'b101, {7'h20, 5'($urandom())}, "srai");
    // word at 0x300, then byte 1 and half 1 overwritten with b
    put_word(s_type(12'h300, 5'd1, 3'b010));
    put_word(s_type(12'h301, 5'd2, 3'b000));
    put_word(s_type(12'h302, 5'd2, 3'b001));
    m = {b_val[15:0], b_val[7:0], a_val[7:0]};
    load_check(3'b010, 12'h300, m, 4, 1'b0, "lw");
    load_check(3'b000, 12'h301, m, 1, 1'b1, "lb");
    load_check(3'b100, 12'h301, m, 1, 1'b0, "lbu");
    load_check(3'b001, 12'h302, m, 2, 1'b1, "lh");
    load_check(3'b101, 12'h302, m, 2, 1'b0, "lhu");
    put_word(ILLEGAL);
  endtask

  task automatic count_error(input int g);
    errors++;
    grp_err[g]++;
  endtask

  task automatic report_group(input int g);
    $display("test %-8s %s", grp_name[g], (grp_err[g] == 0) ? "ok" : "failed");
  endtask

  // command bits as the flash sees them
  always @(posedge flash_clk) begin
    if (!flash_cs && cmd_bits < 32) begin
      cmd_word <= {cmd_word[30:0], flash_mosi};
      cmd_bits <= cmd_bits + 1;
    end
  end

  always @(negedge clk) begin
    if (rst_n && io_valid) begin
      io_count++;
      assert (exp_q.size() > 0)
        else begin
          $display("io_valid pulsed with no report pending, data %h", io_data);
          count_error(G_ILL);
        end
      if (exp_q.size() > 0) begin
        got_exp  = exp_q.pop_front();
        got_grp  = grp_q.pop_front();
        got_name = name_q.pop_front();
        checks++;
        assert (io_data === got_exp)
          else begin
            $display("mismatch %s expected %h actual %h", got_name, got_exp, io_data);
            count_error(got_grp);
          end
        grp_left[got_grp]--;
        if (grp_left[got_grp] == 0) report_group(got_grp);
      end
    end
  end

  initial begin
    int n;
    int io_before;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd_bits = 0;
    cmd_word = '0;
    grp_name = '{"reset", "boot", "alu", "memory", "control", "illegal"};
    void'($urandom(32'h50442664));
    build_program();
    repeat (5) @(negedge clk);
    checks += 3;
    assert (led === 1'b1)
      else begin
        $display("led not high in reset");
        count_error(G_RESET);
      end
    assert (flash_cs === 1'b1)
      else begin
        $display("flash_cs not high in reset");
        count_error(G_RESET);
      end
    assert (io_valid === 1'b0)
      else begin
        $display("io_valid high in reset");
        count_error(G_RESET);
      end
    rst_n = 1'b1;
    report_group(G_RESET);

    n = 0;
    while (flash_cs && n < 200) begin
      @(negedge clk);
      n++;
    end
    n = 0;
    while (!flash_cs && n < 20000) begin
      @(negedge clk);
      n++;
    end
    checks += 2;
    assert (flash_cs === 1'b1)
      else begin
        $display("boot loader never released flash_cs");
        count_error(G_BOOT);
      end
    assert (cmd_bits == 32 && cmd_word == 32'h0300_0000)
      else begin
        $display("mismatch boot_command expected %h actual %h", 32'h0300_0000, cmd_word);
        count_error(G_BOOT);
      end
    report_group(G_BOOT);

    n = 0;
    while (exp_q.size() > 0 && n < 5000) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0)
      else begin
        $display("program stopped with %0d reports missing", exp_q.size());
        count_error(G_ILL);
      end
    for (int g = G_ALU; g <= G_CTRL; g++) begin
      if (grp_left[g] > 0) begin
        grp_err[g]++;
        report_group(g);
      end
    end

    n = 0;
    while (led && n < 200) begin
      @(negedge clk);
      n++;
    end
    io_before = io_count;
    n = 0;
    while (n < 200) begin
      @(negedge clk);
      n++;
    end
    checks += 2;
    assert (led === 1'b0)
      else begin
        $display("led stayed high after the illegal instruction");
        count_error(G_ILL);
      end
    assert (io_count == io_before)
      else begin
        $display("core kept reporting after halting");
        count_error(G_ILL);
      end
    report_group(G_ILL);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/spi_flash_model.sv ====
/*
 * behavioral SPI flash
 * answers the read command 0x03 from a byte array, msb first,
 * pins sampled and driven on the falling system clock
 */
`timescale 1ns/1ps

module spi_flash_model #(
  parameter int DEPTH = 256
) (
  input  logic clk,
  input  logic flash_clk,
  input  logic flash_cs,
  input  logic flash_mosi,
  output logic flash_miso
);

  logic [7:0]  mem [DEPTH];  // loaded by the testbench
  logic        fclk_q;
  logic [5:0]  bit_cnt;
  logic [31:0] cmd;
  logic [23:0] addr;
  logic [2:0]  bit_idx;

  initial begin
    flash_miso = 1'b0;
    fclk_q     = 1'b0;
    bit_cnt    = '0;
    cmd        = '0;
    addr       = '0;
    bit_idx    = '0;
  end

  always @(negedge clk) begin
    fclk_q <= flash_clk;
    if (flash_cs) begin
      bit_cnt <= '0;  // deselected, next command starts over
      bit_idx <= '0;
    end else if (flash_clk && !fclk_q && bit_cnt < 6'd32) begin
      cmd     <= {cmd[30:0], flash_mosi};
      bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt == 6'd31) addr <= {cmd[22:0], flash_mosi};
    end else if (!flash_clk && fclk_q && bit_cnt == 6'd32) begin
      if (cmd[31:24] == 8'h03) flash_miso <= mem[int'(addr) % DEPTH][3'd7 - bit_idx];
      bit_idx <= bit_idx + 3'd1;
      if (bit_idx == 3'd7) addr <= addr + 24'd1;  // next byte
    end
  end

endmodule

// ==== source/soc_top.sv ====
/*
 * rv32i system top
 * core with flash boot on the SPI pins, RAM and output register
 */
`timescale 1ns/1ps

module soc_top (
  input  logic        clk,
  input  logic        rst_n,
  output logic        flash_clk,
  input  logic        flash_miso,
  output logic        flash_mosi,
  output logic        flash_cs,
  output logic        led,
  output logic [31:0] io_data,
  output logic        io_valid
);
  import rv_pkg::*;

  ramio_req_t  ram_req;
  logic [31:0] ram_rdata;
  logic        ram_ready;
  logic        ram_busy;

  rv_core u_core (
    .clk, .rst_n, .flash_clk, .flash_mosi, .flash_cs, .flash_miso,
    .ram_req, .ram_rdata, .ram_ready, .ram_busy, .led
  );

  ram_io u_ram_io (
    .clk, .rst_n, .req(ram_req), .rdata(ram_rdata), .ready(ram_ready),
    .busy(ram_busy), .io_data, .io_valid
  );

endmodule

// ==== source/ram_io.sv ====
/*
 * on-chip RAM with byte lanes and a memory-mapped output register
 * reads answer one cycle after acceptance, writes hold busy for one cycle
 */
`timescale 1ns/1ps

module ram_io (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_pkg::ramio_req_t req,
  output logic [31:0]        rdata,
  output logic               ready,
  output logic               busy,
  output logic [31:0]        io_data,
  output logic               io_valid
);
  import rv_pkg::*;

  localparam int unsigned IDX_W = $clog2(RAM_WORDS);

  logic [31:0]      mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [4:0]       shamt;
  logic             accept, is_io, do_read, do_write;
  logic [3:0]       lane_en;
  logic [31:0]      lane_data;
  logic [31:0]      rd_word;

  assign idx       = req.address[IDX_W+1:2];
  assign shamt     = {req.address[1:0], 3'b000};
  assign accept    = req.enable && !busy;
  assign is_io     = (req.address == IO_ADDR);
  assign do_read   = accept && (req.read_type != RD_NONE);
  assign do_write  = accept && (req.write_type != WR_NONE);
  assign lane_data = req.wdata << shamt;
  assign rd_word   = mem[idx] >> shamt;  // addressed byte moved to [7:0]

  always_comb begin
    case (req.write_type)
      WR_B:    lane_en = 4'b0001 << req.address[1:0];
      WR_H:    lane_en = 4'b0011 << req.address[1:0];
      WR_W:    lane_en = 4'b1111;
      default: lane_en = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (do_write && !is_io) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
      end
    end
    if (do_read) begin
      case (req.read_type[1:0])
        2'b01:   rdata <= {{24{req.read_type[2] & rd_word[7]}}, rd_word[7:0]};
        2'b10:   rdata <= {{16{req.read_type[2] & rd_word[15]}}, rd_word[15:0]};
        default: rdata <= rd_word;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready    <= 1'b0;
      busy     <= 1'b0;
      io_valid <= 1'b0;
      io_data  <= '0;
    end else begin
      ready    <= do_read;   // one-cycle pulse
      busy     <= do_write;
      io_valid <= do_write && is_io;
      if (do_write && is_io) io_data <= req.wdata;
    end
  end

  // core and boot loader never mix a read and a write in one request
  assert property (@(posedge clk) disable iff (!rst_n)
    req.enable |-> (req.read_type == RD_NONE || req.write_type == WR_NONE))
    else $error("read and write requested together at %h", req.address);

endmodule

// ==== source/rv_core.sv ====
/*
 * multi-cycle rv32i core
 * boots through flash_boot, then walks fetch, execute, store and load
 * over the ramio bus
 */
`timescale 1ns/1ps

module rv_core (
  input  logic               clk,
  input  logic               rst_n,
  output logic               flash_clk,
  output logic               flash_mosi,
  output logic               flash_cs,
  input  logic               flash_miso,
  output rv_pkg::ramio_req_t ram_req,
  input  logic [31:0]        ram_rdata,
  input  logic               ram_ready,
  input  logic               ram_busy,
  output logic               led
);
  import rv_pkg::*;

  typedef enum logic [2:0] {S_BOOT, S_FETCH, S_WAIT, S_EXEC, S_STORE, S_LOAD, S_HALT} state_e;

  state_e      state;
  logic [31:0] pc;
  logic [31:0] ir;
  logic        boot_done;
  ramio_req_t  boot_req;
  ramio_req_t  core_req;
  decoded_t    dec;
  exec_t       ex;
  logic [31:0] rs1_data, rs2_data;
  logic        rf_we;
  logic [31:0] rf_wdata;
  logic        mem_op;

  assign mem_op   = (ex.mem_read_type != RD_NONE) || (ex.mem_write_type != WR_NONE);
  assign ram_req  = boot_done ? core_req : boot_req;
  assign rf_we    = (state == S_EXEC && ex.rd_we) || (state == S_LOAD && ram_ready);
  assign rf_wdata = (state == S_LOAD) ? ram_rdata : ex.rd_value;

  always_comb begin
    core_req = '0;
    if (state == S_FETCH) begin
      core_req.enable    = 1'b1;
      core_req.read_type = RD_W;
      core_req.address   = pc;
    end else if (state == S_EXEC && mem_op) begin
      core_req.enable     = 1'b1;
      core_req.read_type  = ex.mem_read_type;
      core_req.write_type = ex.mem_write_type;
      core_req.address    = ex.mem_addr;
      core_req.wdata      = ex.mem_wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_BOOT;
      pc    <= '0;
      ir    <= '0;
      led   <= 1'b1;
    end else begin
      case (state)
        S_BOOT:  if (boot_done) state <= S_FETCH;  // run from address 0
        S_FETCH: if (!ram_busy) state <= S_WAIT;
        S_WAIT: begin
          if (ram_ready) begin
            ir    <= ram_rdata;
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (dec.op_class == CL_ILLEGAL) begin
            led   <= 1'b0;
            state <= S_HALT;
          end else if (!mem_op) begin
            pc    <= ex.next_pc;
            state <= S_FETCH;
          end else if (!ram_busy) begin  // memory request taken
            pc    <= ex.next_pc;
            state <= (ex.mem_write_type != WR_NONE) ? S_STORE : S_LOAD;
          end
        end
        S_STORE: if (!ram_busy) state <= S_FETCH;
        S_LOAD:  if (ram_ready) state <= S_FETCH;  // ir still names rd here
        default: ;  // halted
      endcase
    end
  end

  flash_boot u_flash_boot (
    .clk, .rst_n, .flash_clk, .flash_mosi, .flash_cs, .flash_miso,
    .req(boot_req), .busy(ram_busy), .done(boot_done)
  );

  rv_decode u_decode (.ir, .dec);

  rv_execute u_execute (.dec, .pc, .rs1_data, .rs2_data, .ex);

  rv_result u_result (
    .clk, .rst_n, .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
    .we(rf_we), .wdata(rf_wdata), .rs1_data, .rs2_data
  );

endmodule

// ==== source/rv_result.sv ====
/*
 * rv32i register file
 * two combinational read ports, one write port, x0 reads as zero
 */
`timescale 1ns/1ps

module rv_result (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;  // x0 writes dropped
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 must stay zero across every write-back
  assert property (@(posedge clk) disable iff (!rst_n)
    (rs1 == 5'd0) |-> (rs1_data == 32'd0))
    else $error("x0 read back nonzero %h", rs1_data);

endmodule

// ==== source/rv_execute.sv ====
/*
 * rv32i execute stage
 * ALU, compare and branch decision, next pc, link value
 * and the memory request of loads and stores
 */
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::decoded_t dec,
  input  logic [31:0]      pc,
  input  logic [31:0]      rs1_data,
  input  logic [31:0]      rs2_data,
  output rv_pkg::exec_t    ex
);
  import rv_pkg::*;

  logic [31:0] op_b;
  logic [31:0] alu;
  logic [31:0] pc_plus4;
  logic        sub;
  logic        taken;

  assign op_b     = (dec.op_class == CL_OP) ? rs2_data : dec.imm;
  assign sub      = (dec.op_class == CL_OP) && dec.alt;  // addi ignores bit 30
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (dec.funct3)
      3'b000:  alu = sub ? rs1_data - op_b : rs1_data + op_b;
      3'b001:  alu = rs1_data << op_b[4:0];
      3'b010:  alu = {31'd0, $signed(rs1_data) < $signed(op_b)};
      3'b011:  alu = {31'd0, rs1_data < op_b};
      3'b100:  alu = rs1_data ^ op_b;
      3'b101:  alu = dec.alt ? 32'($signed(rs1_data) >>> op_b[4:0]) : rs1_data >> op_b[4:0];
      3'b110:  alu = rs1_data | op_b;
      default: alu = rs1_data & op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  taken = (rs1_data == rs2_data);
      3'b001:  taken = (rs1_data != rs2_data);
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      default: taken = rs1_data >= rs2_data;  // bgeu
    endcase
  end

  always_comb begin
    ex           = '0;
    ex.next_pc   = pc_plus4;
    ex.mem_addr  = rs1_data + dec.imm;
    ex.mem_wdata = rs2_data;
    case (dec.op_class)
      CL_LUI: begin
        ex.rd_value = dec.imm;
        ex.rd_we    = 1'b1;
      end
      CL_AUIPC: begin
        ex.rd_value = pc + dec.imm;
        ex.rd_we    = 1'b1;
      end
      CL_OP_IMM, CL_OP: begin
        ex.rd_value = alu;
        ex.rd_we    = 1'b1;
      end
      CL_JAL: begin
        ex.rd_value = pc_plus4;  // link
        ex.rd_we    = 1'b1;
        ex.next_pc  = pc + dec.imm;
      end
      CL_JALR: begin
        ex.rd_value = pc_plus4;
        ex.rd_we    = 1'b1;
        ex.next_pc  = {ex.mem_addr[31:1], 1'b0};
      end
      CL_BRANCH: if (taken) ex.next_pc = pc + dec.imm;
      CL_LOAD: begin
        case (dec.funct3)
          3'b000:  ex.mem_read_type = RD_B;
          3'b001:  ex.mem_read_type = RD_H;
          3'b010:  ex.mem_read_type = RD_W;
          3'b100:  ex.mem_read_type = RD_BU;
          default: ex.mem_read_type = RD_HU;
        endcase
      end
      CL_STORE: begin
        case (dec.funct3)
          3'b000:  ex.mem_write_type = WR_B;
          3'b001:  ex.mem_write_type = WR_H;
          default: ex.mem_write_type = WR_W;
        endcase
      end
      default: ;  // illegal halts the core
    endcase
  end

  // program must keep branch and jal targets word aligned
  always_comb begin
    if (dec.op_class == CL_BRANCH || dec.op_class == CL_JAL) begin
      assert final (ex.next_pc[1:0] == 2'b00)
        else $error("misaligned control transfer target %h", ex.next_pc);
    end
  end

endmodule

// ==== source/rv_decode.sv ====
/*
 * rv32i instruction decoder
 * splits the word into fields, picks the immediate for the class
 * and flags unsupported encodings as illegal
 */
`timescale 1ns/1ps

module rv_decode (
  input  logic [31:0]      ir,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  logic [2:0]  f3;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign f3    = ir[14:12];
  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'd0};
  assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

  always_comb begin
    dec          = '0;
    dec.funct3   = f3;
    dec.alt      = ir[30];
    dec.rs1      = ir[19:15];
    dec.rs2      = ir[24:20];
    dec.rd       = ir[11:7];
    dec.op_class = CL_ILLEGAL;
    case (ir[6:0])
      OPC_LUI: begin
        dec.op_class = CL_LUI;
        dec.imm      = imm_u;
      end
      OPC_AUIPC: begin
        dec.op_class = CL_AUIPC;
        dec.imm      = imm_u;
      end
      OPC_JAL: begin
        dec.op_class = CL_JAL;
        dec.imm      = imm_j;
      end
      OPC_JALR: begin
        dec.op_class = (f3 == 3'b000) ? CL_JALR : CL_ILLEGAL;
        dec.imm      = imm_i;
      end
      OPC_BRANCH: begin
        dec.op_class = (f3[2:1] == 2'b01) ? CL_ILLEGAL : CL_BRANCH;  // 010, 011 unused
        dec.imm      = imm_b;
      end
      OPC_LOAD: begin
        dec.op_class = (f3 == 3'b011 || f3[2:1] == 2'b11) ? CL_ILLEGAL : CL_LOAD;
        dec.imm      = imm_i;
      end
      OPC_STORE: begin
        dec.op_class = (f3[2] || f3[1:0] == 2'b11) ? CL_ILLEGAL : CL_STORE;
        dec.imm      = imm_s;
      end
      OPC_OP_IMM: begin
        dec.op_class = CL_OP_IMM;
        dec.imm      = imm_i;
      end
      OPC_OP:     dec.op_class = CL_OP;
      default:    dec.op_class = CL_ILLEGAL;  // fence, system and unknown
    endcase
  end

endmodule

// ==== source/flash_boot.sv ====
/*
 * SPI flash boot loader
 * sends read command 0x03 at address 0 and copies the boot image
 * into RAM one little-endian word at a time
 */
`timescale 1ns/1ps

module flash_boot (
  input  logic               clk,
  input  logic               rst_n,
  output logic               flash_clk,
  output logic               flash_mosi,
  output logic               flash_cs,
  input  logic               flash_miso,
  output rv_pkg::ramio_req_t req,
  input  logic               busy,
  output logic               done
);
  import rv_pkg::*;

  localparam int unsigned WAIT_W = $clog2(STARTUP_WAIT_CYCLES);

  typedef enum logic [2:0] {B_WAIT, B_SEND, B_READ, B_WRITE, B_WDONE, B_DONE} boot_state_e;

  boot_state_e       state;
  logic [WAIT_W-1:0] cnt;
  logic              ph;       // low or high half of an SPI bit
  logic [4:0]        bit_cnt;
  logic [31:0]       cmd_sr;
  logic [31:0]       addr;
  logic [7:0]        byte_sr;
  logic [31:0]       word;

  always_comb begin
    req            = '0;
    req.enable     = (state == B_WRITE);
    req.read_type  = RD_NONE;
    req.write_type = WR_W;
    req.address    = addr;
    req.wdata      = word;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= B_WAIT;
      cnt        <= '0;
      ph         <= 1'b0;
      bit_cnt    <= '0;
      cmd_sr     <= '0;
      addr       <= '0;
      flash_clk  <= 1'b0;
      flash_mosi <= 1'b0;
      flash_cs   <= 1'b1;
      done       <= 1'b0;
    end else begin
      case (state)
        B_WAIT: begin
          cnt <= cnt + 1'b1;
          if (cnt == WAIT_W'(STARTUP_WAIT_CYCLES - 1)) begin
            flash_cs <= 1'b0;
            cmd_sr   <= {8'h03, 24'h00_0000};  // read command, address 0
            state    <= B_SEND;
          end
        end
        B_SEND: begin
          ph <= ~ph;
          if (!ph) begin
            flash_clk  <= 1'b0;
            flash_mosi <= cmd_sr[31];  // msb first
            cmd_sr     <= {cmd_sr[30:0], 1'b0};
          end else begin
            flash_clk <= 1'b1;
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == 5'd31) state <= B_READ;
          end
        end
        B_READ: begin
          ph        <= ~ph;
          flash_clk <= ph;  // falling edge lets the flash shift out
          if (ph) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 5'd31) state <= B_WRITE;
          end
        end
        B_WRITE: begin
          if (!busy) begin
            addr  <= addr + 32'd4;
            state <= B_WDONE;
          end
        end
        B_WDONE: begin
          if (!busy) begin
            if (addr == BOOT_BYTES) begin
              flash_cs  <= 1'b1;
              flash_clk <= 1'b0;
              done      <= 1'b1;
              state     <= B_DONE;
            end else begin
              state <= B_READ;
            end
          end
        end
        default: ;  // boot finished
      endcase
    end
  end

  // sample miso just before the rising edge, first byte ends up in [7:0]
  always_ff @(posedge clk) begin
    if (state == B_READ && ph) begin
      byte_sr <= {byte_sr[6:0], flash_miso};
      if (bit_cnt[2:0] == 3'd7) word <= {byte_sr[6:0], flash_miso, word[31:8]};
    end
  end

endmodule

// ==== source/rv_pkg.sv ====
/*
 * rv32i system package
 * boot and memory sizing, opcode values, ramio access codes
 * and the structs passed between the core blocks
 */
package rv_pkg;

  localparam int unsigned BOOT_BYTES          = 256;
  localparam int unsigned STARTUP_WAIT_CYCLES = 16;
  localparam int unsigned RAM_WORDS           = 256;
  localparam logic [31:0] IO_ADDR             = 32'hFFFF_FF00;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // bit 2 flags sign extension
  typedef enum logic [2:0] {
    RD_NONE = 3'b000,
    RD_BU   = 3'b001,
    RD_HU   = 3'b010,
    RD_B    = 3'b101,
    RD_H    = 3'b110,
    RD_W    = 3'b111
  } read_type_e;

  typedef enum logic [1:0] {
    WR_NONE = 2'b00,
    WR_B    = 2'b01,
    WR_H    = 2'b10,
    WR_W    = 2'b11
  } write_type_e;

  typedef enum logic [3:0] {
    CL_LUI, CL_AUIPC, CL_JAL, CL_JALR, CL_BRANCH,
    CL_LOAD, CL_STORE, CL_OP_IMM, CL_OP, CL_ILLEGAL
  } op_class_e;

  typedef struct packed {
    logic        enable;
    read_type_e  read_type;
    write_type_e write_type;
    logic [31:0] address;
    logic [31:0] wdata;
  } ramio_req_t;

  typedef struct packed {
    op_class_e   op_class;
    logic [2:0]  funct3;
    logic        alt;     // instruction bit 30
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
  } decoded_t;

  typedef struct packed {
    logic [31:0] rd_value;
    logic        rd_we;
    logic [31:0] next_pc;
    logic [31:0] mem_addr;
    read_type_e  mem_read_type;
    write_type_e mem_write_type;
    logic [31:0] mem_wdata;
  } exec_t;

endpackage
